//--- Makefile
# Verilator build and run of the async FIFO testbench
TOP := tb_afifo

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- afifo.sv
// Asynchronous FIFO, write on i_wclk and read on gbl_clk
// Holds 2**AFIFO_LGFIFO words in storage plus one in the output
`timescale 1ns/1ns
`include "afifo_params.svh"

module afifo
	import fifo_data_pkg::*;
	import fifo_ptr_pkg::*;
(
	// Write domain
	input  logic  i_wclk,
	input  logic  i_wr_reset_n,
	input  logic  i_wr,
	input  data_t i_wr_data,
	output logic  o_wr_full,
	// Read domain
	input  logic  gbl_clk,
	input  logic  i_rd_reset_n,
	input  logic  i_rd,
	output data_t o_rd_data,
	output logic  o_rd_empty
);

	// Storage write port
	logic  wr_en;
	addr_t wr_addr;
	data_t wr_data;
	// Storage read port
	addr_t rd_addr;
	data_t rd_data;
	// Pointers and their synchronized copies
	ptr_t  wgray;
	ptr_t  rgray;
	ptr_t  rd_wgray;
	ptr_t  wr_rgray;

	//////////////////////////////////////////////////////////////////////
	// Write domain
	//////////////////////////////////////////////////////////////////////

	wr_ptr_ctl u_wr_ptr_ctl (
		.i_wclk        (i_wclk),
		.i_wr_reset_n  (i_wr_reset_n),
		.i_wr          (i_wr),
		.i_wr_data     (i_wr_data),
		.i_wr_rgray    (wr_rgray),
		.o_wr_full     (o_wr_full),
		.o_mem_wr_en   (wr_en),
		.o_mem_wr_addr (wr_addr),
		.o_mem_wr_data (wr_data),
		.o_wgray       (wgray)
	);

	// Read pointer into the write domain
	gray_sync #(.NFF(`AFIFO_NFF)) sync_r2w (
		.i_clk     (i_wclk),
		.i_reset_n (i_wr_reset_n),
		.i_gray    (rgray),
		.o_gray    (wr_rgray)
	);

	// Shared storage
	fifo_mem u_fifo_mem (
		.i_wclk    (i_wclk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Read domain
	//////////////////////////////////////////////////////////////////////

	// Write pointer into the read domain
	gray_sync #(.NFF(`AFIFO_NFF)) sync_w2r (
		.i_clk     (gbl_clk),
		.i_reset_n (i_rd_reset_n),
		.i_gray    (wgray),
		.o_gray    (rd_wgray)
	);

	rd_ptr_ctl u_rd_ptr_ctl (
		.gbl_clk       (gbl_clk),
		.i_rd_reset_n  (i_rd_reset_n),
		.i_rd          (i_rd),
		.i_rd_wgray    (rd_wgray),
		.i_mem_rd_data (rd_data),
		.o_mem_rd_addr (rd_addr),
		.o_rgray       (rgray),
		.o_rd_data     (o_rd_data),
		.o_rd_empty    (o_rd_empty)
	);

endmodule

//--- afifo_params.svh
// FIFO geometry defaults, shared by both packages and the top level
// AFIFO_LGFIFO must be 2 or more for the full compare to stay legal
`ifndef AFIFO_PARAMS_SVH
`define AFIFO_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Storage geometry
//////////////////////////////////////////////////////////////////////

// Log base two of the storage depth
`define AFIFO_LGFIFO 3

// Data bits per entry
`define AFIFO_WIDTH 16

//////////////////////////////////////////////////////////////////////
// Clock domain crossing
//////////////////////////////////////////////////////////////////////

// Flops per synchronizer chain, two at least
`define AFIFO_NFF 2

`endif

//--- fifo_data_pkg.sv
// Payload types carried through the FIFO
// Width comes from AFIFO_WIDTH in the params header
package fifo_data_pkg;

	`include "afifo_params.svh"

	//////////////////////////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////////////////////////

	// One storage entry, written in the write domain
	// and presented registered in the read domain
	typedef logic [`AFIFO_WIDTH-1:0] data_t;

endpackage

//--- fifo_mem.sv
// Dual-port storage, clocked write and combinational read
// Contents are undefined until written, there is no reset
`timescale 1ns/1ns

module fifo_mem
	import fifo_data_pkg::*;
	import fifo_ptr_pkg::*;
(
	input  logic  i_wclk,
	input  logic  i_wr_en,
	input  addr_t i_wr_addr,
	input  data_t i_wr_data,
	input  addr_t i_rd_addr,
	output data_t o_rd_data
);

	// Depth follows the address width
	localparam int DEPTH = 1 << $bits(addr_t);

	data_t mem [DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Write port, write clock domain
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_wclk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	//////////////////////////////////////////////////////////////////////
	// Read port, no clock
	//////////////////////////////////////////////////////////////////////

	// Reader registers the word itself
	assign o_rd_data = mem[i_rd_addr];

endmodule

//--- fifo_ptr_pkg.sv
// Pointer, address and crossing types of the FIFO
// Pointers carry one extra wrap bit above the storage address
package fifo_ptr_pkg;

	`include "afifo_params.svh"

	//////////////////////////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////////////////////////

	// Binary or Gray pointer
	// Top bit toggles on each pass through the storage
	typedef logic [`AFIFO_LGFIFO:0] ptr_t;

	//////////////////////////////////////////////////////////////////////
	// Storage index
	//////////////////////////////////////////////////////////////////////

	// Low bits of the binary pointer
	typedef logic [`AFIFO_LGFIFO-1:0] addr_t;

endpackage

//--- gray_sync.sv
// Synchronizer for a Gray pointer, NFF destination cycles of latency
// Source must be Gray coded so no sample is torn
`timescale 1ns/1ns

module gray_sync
	import fifo_ptr_pkg::*;
#(
	parameter int NFF = 2
) (
	input  logic i_clk,
	input  logic i_reset_n,
	input  ptr_t i_gray,
	output ptr_t o_gray
);

	// Fewer than two flops gives no metastability margin
	if (NFF < 2)
	begin : g_nff_check
		$error("gray_sync needs NFF of at least 2");
	end

	// Crossing chain, stage 0 samples the foreign domain
	(* ASYNC_REG = "TRUE" *) ptr_t sync_q [NFF];

	always_ff @(posedge i_clk or negedge i_reset_n)
	begin
		if (!i_reset_n)
		begin
			for (int i = 0; i < NFF; i++)
				sync_q[i] <= '0;
		end
		else
		begin
			sync_q[0] <= i_gray;
			// Shift toward the output
			for (int i = 1; i < NFF; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	// Last stage is the settled value
	assign o_gray = sync_q[NFF-1];

endmodule

//--- rd_ptr_ctl.sv
// Read pointer, empty detection and the registered output stage
// Output word and empty flag are registered, the stage prefetches
`timescale 1ns/1ns

module rd_ptr_ctl
	import fifo_data_pkg::*;
	import fifo_ptr_pkg::*;
(
	input  logic  gbl_clk,
	input  logic  i_rd_reset_n,
	input  logic  i_rd,
	input  ptr_t  i_rd_wgray,
	input  data_t i_mem_rd_data,
	output addr_t o_mem_rd_addr,
	output ptr_t  o_rgray,
	output data_t o_rd_data,
	output logic  o_rd_empty
);

	// Top bit of the pointer
	localparam int MSB = $bits(ptr_t) - 1;

	ptr_t rd_bin;
	ptr_t rd_bin_next;
	ptr_t rgray;
	logic lcl_empty;
	logic lcl_read;

	// Gray to binary, top bit down
	function automatic ptr_t gray_to_bin(input ptr_t g);
		ptr_t b;
		b[MSB] = g[MSB];
		for (int i = MSB - 1; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Local empty and load decision
	//////////////////////////////////////////////////////////////////////

	// Nothing in storage beyond what the output holds
	assign lcl_empty = (i_rd_wgray == rgray);

	// Load when the output slot is free or being consumed
	assign lcl_read = o_rd_empty || i_rd;

	//////////////////////////////////////////////////////////////////////
	// Pointer update
	//////////////////////////////////////////////////////////////////////

	assign rd_bin_next = rd_bin + ptr_t'(1);

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rd_bin <= '0;
			rgray  <= '0;
		end
		else if (lcl_read && !lcl_empty)
		begin
			rd_bin <= rd_bin_next;
			rgray  <= rd_bin_next ^ (rd_bin_next >> 1);
		end
	end

	assign o_mem_rd_addr = rd_bin[MSB-1:0];
	assign o_rgray       = rgray;

	//////////////////////////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////////////////////////

	// Empty flag, set out of reset
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
			o_rd_empty <= 1'b1;
		else if (lcl_read)
			o_rd_empty <= lcl_empty;
	end

	// Data word, meaningful only while o_rd_empty is low
	always_ff @(posedge gbl_clk)
	begin
		if (lcl_read)
			o_rd_data <= i_mem_rd_data;
	end

	// Reader never passes the synchronized writer
	a_no_underrun: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		ptr_t'(gray_to_bin(i_rd_wgray) - rd_bin) <= ptr_t'(1 << MSB));

endmodule

//--- sources.f
+incdir+.
fifo_data_pkg.sv
fifo_ptr_pkg.sv
gray_sync.sv
fifo_mem.sv
wr_ptr_ctl.sv
rd_ptr_ctl.sv
afifo.sv
tb_afifo.sv

//--- tb_afifo.sv
// Directed testbench for the async FIFO, write on i_wclk and read on gbl_clk
// Inputs change on falling edges, flags are sampled there before each decision
`timescale 1ns/1ns
`include "afifo_params.svh"

module tb_afifo
	import fifo_data_pkg::*;
();

	localparam int DEPTH = 1 << `AFIFO_LGFIFO;
	// About four times the summed length of all tests
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [31:0] SEED = 32'hb3586e0b;

	logic  i_wclk;
	logic  i_wr_reset_n;
	logic  i_wr;
	data_t i_wr_data;
	logic  o_wr_full;
	logic  gbl_clk;
	logic  i_rd_reset_n;
	logic  i_rd;
	data_t o_rd_data;
	logic  o_rd_empty;

	// Reference model of the FIFO contents, head is the next word out
	data_t       model_q [$];
	logic [31:0] wr_rng;
	logic [31:0] rd_rng;
	logic        writer_done;
	int          cycle_count;

	afifo UUT (
		.i_wclk       (i_wclk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.o_wr_full    (o_wr_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

	// Read clock 8 ns, write clock 11 ns
	always #4 gbl_clk = ~gbl_clk;

	always
	begin
		#6 i_wclk = 1'b1;
		#5 i_wclk = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// One write cycle, full is stable from here to the next rising edge
	task automatic write_step(input logic want, input data_t d, output logic took);
		@(negedge i_wclk);
		took = want && !o_wr_full;
		if (took)
			model_q.push_back(d);
		i_wr      = want;
		i_wr_data = d;
	endtask

	// One read cycle, the word shown now is the one taken at the next edge
	task automatic read_step(input logic want, output logic took);
		@(negedge gbl_clk);
		took = want && !o_rd_empty;
		if (took)
		begin
			if (model_q.size() == 0)
			begin
				$display("DUT offered a word while the model queue was empty");
				abort_run();
			end
			check_data(o_rd_data, model_q.pop_front(), "read data");
		end
		i_rd = want;
	endtask

	// Read until the output has stayed empty for 16 cycles
	task automatic drain_all(input string what);
		int   idle;
		logic took;
		idle = 0;
		while (idle < 16)
		begin
			read_step(1'b1, took);
			idle = took ? 0 : idle + 1;
		end
		check_flag(model_q.size() == 0, 1'b1, {"model empty ", what});
		check_flag(o_rd_empty, 1'b1, {"o_rd_empty ", what});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic single_word_test();
		logic  took;
		data_t d;
		wr_rng = xorshift(wr_rng);
		d = data_t'(wr_rng[31:16]);
		write_step(1'b1, d, took);
		check_flag(took, 1'b1, "single write accepted");
		write_step(1'b0, '0, took);
		// Wait for the word to cross and load
		read_step(1'b0, took);
		while (o_rd_empty)
			read_step(1'b0, took);
		check_data(o_rd_data, d, "single word shown");
		repeat (5)
		begin
			read_step(1'b0, took);
			check_data(o_rd_data, d, "single word held");
			check_flag(o_rd_empty, 1'b0, "empty while word held");
		end
		read_step(1'b1, took);
		read_step(1'b0, took);
		check_flag(o_rd_empty, 1'b1, "empty after single read");
	endtask

	task automatic fill_test();
		int   accepted;
		int   full_run;
		logic took;
		accepted = 0;
		full_run = 0;
		while (full_run < 20)
		begin
			write_step(1'b1, data_t'(32'ha500 + accepted), took);
			if (took)
			begin
				accepted++;
				full_run = 0;
			end
			else
				full_run++;
		end
		write_step(1'b0, '0, took);
		// Storage plus the output register, one less if a read pointer lags
		check_flag(accepted >= DEPTH && accepted <= DEPTH + 1, 1'b1, "accepted write count");
	endtask

	task automatic random_stream_test();
		logic took_w;
		logic took_r;
		writer_done = 1'b0;
		fork
			begin
				repeat (300)
				begin
					wr_rng = xorshift(wr_rng);
					write_step(wr_rng[1:0] != 2'b00, data_t'(wr_rng[31:16]), took_w);
				end
				write_step(1'b0, '0, took_w);
				writer_done = 1'b1;
			end
			begin
				while (!writer_done)
				begin
					rd_rng = xorshift(rd_rng);
					read_step(rd_rng[0], took_r);
				end
			end
		join
		drain_all("after random traffic");
	endtask

	// Hang guard
	always @(posedge gbl_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run still going after %0d gbl_clk cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	initial
	begin
		gbl_clk      = 1'b0;
		i_wclk       = 1'b0;
		i_wr_reset_n = 1'b0;
		i_rd_reset_n = 1'b0;
		i_wr         = 1'b0;
		i_wr_data    = '0;
		i_rd         = 1'b0;
		wr_rng       = SEED;
		rd_rng       = ~SEED;
		writer_done  = 1'b0;
		cycle_count  = 0;
		repeat (3) @(posedge gbl_clk);
		@(negedge gbl_clk);
		i_wr_reset_n = 1'b1;
		i_rd_reset_n = 1'b1;
		@(negedge gbl_clk);
		check_flag(o_rd_empty, 1'b1, "o_rd_empty after reset");
		check_flag(o_wr_full, 1'b0, "o_wr_full after reset");
		single_word_test();
		fill_test();
		drain_all("after fill");
		random_stream_test();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- wr_ptr_ctl.sv
// Write pointer, its Gray copy and the full flag
// Full is combinational and may lag a read by the sync latency
`timescale 1ns/1ns

module wr_ptr_ctl
	import fifo_data_pkg::*;
	import fifo_ptr_pkg::*;
(
	input  logic  i_wclk,
	input  logic  i_wr_reset_n,
	input  logic  i_wr,
	input  data_t i_wr_data,
	input  ptr_t  i_wr_rgray,
	output logic  o_wr_full,
	output logic  o_mem_wr_en,
	output addr_t o_mem_wr_addr,
	output data_t o_mem_wr_data,
	output ptr_t  o_wgray
);

	// Top bit of the pointer
	localparam int MSB = $bits(ptr_t) - 1;

	ptr_t wr_bin;
	ptr_t wr_bin_next;
	ptr_t wgray;
	logic wr_accept;

	// Gray to binary, top bit down
	function automatic ptr_t gray_to_bin(input ptr_t g);
		ptr_t b;
		b[MSB] = g[MSB];
		for (int i = MSB - 1; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Full detection
	//////////////////////////////////////////////////////////////////////

	// Read pointer one lap behind
	// In Gray code that is the two top bits inverted
	assign o_wr_full = (i_wr_rgray == {~wgray[MSB:MSB-1], wgray[MSB-2:0]});

	// Writes while full are dropped
	assign wr_accept = i_wr && !o_wr_full;

	//////////////////////////////////////////////////////////////////////
	// Pointer update
	//////////////////////////////////////////////////////////////////////

	assign wr_bin_next = wr_bin + ptr_t'(1);

	always_ff @(posedge i_wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wr_bin <= '0;
			wgray  <= '0;
		end
		else if (wr_accept)
		begin
			wr_bin <= wr_bin_next;
			// Gray copy registered too, so the crossing sees clean edges
			wgray  <= wr_bin_next ^ (wr_bin_next >> 1);
		end
	end

	// Storage write port
	assign o_mem_wr_en   = wr_accept;
	assign o_mem_wr_addr = wr_bin[MSB-1:0];
	assign o_mem_wr_data = i_wr_data;

	assign o_wgray = wgray;

	// Never more than a full storage ahead of the synchronized reader
	a_no_overrun: assert property (@(posedge i_wclk) disable iff (!i_wr_reset_n)
		ptr_t'(wr_bin - gray_to_bin(i_wr_rgray)) <= ptr_t'(1 << MSB));

endmodule
